// File: music_player.f
hdl/song_pkg.sv
hdl/synth_pkg.sv
hdl/song_rom.sv
hdl/song_reader.sv
hdl/beat_generator.sv
hdl/voice_allocator.sv
hdl/note_player.sv
hdl/music_player.sv
tb/tb_music_player.sv

// File: Bender.yml
package:
  name: music_player

sources:
  - hdl/song_pkg.sv
  - hdl/synth_pkg.sv
  - hdl/song_rom.sv
  - hdl/song_reader.sv
  - hdl/beat_generator.sv
  - hdl/voice_allocator.sv
  - hdl/note_player.sv
  - hdl/music_player.sv
  - target: simulation
    files:
      - tb/tb_music_player.sv

// File: songs.mem
// One 16-bit word per entry, hex: hold[15] note[14:9] duration[8:3] spare[2:0].
// Songs start at 00, 20, 40 and 60; words not listed read as zero.
@00
8A10
9008
@20
9410
2820
3220
BA20
8018
9A00
9E08
A200
A408
2C00
B000
@3F
BC00
@40
8A08
9000
1808
@60
9A08

// File: tb/tb_music_player.sv
`timescale 1ns/10ps
`default_nettype none

module tb_music_player;
    import synth_pkg::*;

    localparam int CLK_HALF = 10;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 20;
    localparam int MAX_PAUSE = 40;
    localparam int AFTER_END_CYCLES = 150;
    localparam int NOTE_LIMIT = 67 * BEAT_CYCLES;  // Longest note plus slack.

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  play;
    logic [1:0]            song;
    logic                  song_done;
    logic                  new_note;
    note_event_t           note_event;
    logic [NUM_VOICES-1:0] busy;
    logic [1:0]            audio;

    logic [15:0] model_rom [128];
    int          played;     // Notes seen so far in the current song.
    int          done_seen;

    music_player dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .play       (play),
        .song       (song),
        .song_done  (song_done),
        .new_note   (new_note),
        .note_event (note_event),
        .busy       (busy),
        .audio      (audio)
    );

    always #CLK_HALF clk = ~clk;

    // Worst case for one song: every held entry waits its full length.
    function automatic int song_cycles(input int s);
        int          total;
        logic [15:0] w;
        total = 0;
        for (int e = 0; e < 32; e++) begin
            w = model_rom[s * 32 + e];
            total += 4;
            if (w[15]) begin
                total += (int'(w[8:3]) + 2) * BEAT_CYCLES;
            end
        end
        return total;
    endfunction

    function automatic int busy_count(input logic [NUM_VOICES-1:0] b);
        int n;
        n = 0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            n += int'(b[i]);
        end
        return n;
    endfunction

    // First idle voice from index 0 up, or voice 0 when all are busy.
    function automatic int lowest_idle(input logic [NUM_VOICES-1:0] b);
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (!b[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Every cycle goes through here, so each new note is compared in order.
    task automatic step();
        int idx;
        @(negedge clk);
        if (new_note) begin
            if (played >= 32) begin
                $display("A new note arrived after the last entry of the song.");
                abort_run();
            end else begin
                idx = int'(song) * 32 + played;
                check_value("note_event.note", note_event.note, model_rom[idx][14:9]);
                check_value("note_event.duration", note_event.duration, model_rom[idx][8:3]);
                played++;
            end
        end
        if (song_done) begin
            check_value("notes before song_done", played, 32);
            done_seen++;
            played = 0;
        end
    endtask

    task automatic wait_for_entry(input int entry, input int max_cycles, output int cycles);
        cycles = 0;
        while (played <= entry) begin
            if (cycles >= max_cycles) begin
                $display("Entry %0d did not arrive within %0d cycles.", entry, max_cycles);
                abort_run();
            end else begin
                step();
                cycles++;
            end
        end
    endtask

    task automatic idle_after_reset();
        repeat (IDLE_CYCLES) begin
            step();
            check_value("new_note", new_note, 0);
            check_value("song_done", song_done, 0);
            check_value("busy", busy, 0);
            check_value("audio", audio, 0);
        end
    endtask

    // Entry 0 of song 1 is a held pitched note on its own.
    task automatic held_note_and_tone();
        int cycles;
        bit saw_low;
        bit saw_high;
        saw_low = 1'b0;
        saw_high = 1'b0;
        play = 1'b1;
        wait_for_entry(0, 8, cycles);
        check_value("cycles from play to new_note", cycles, 2);
        step();
        step();
        check_value("busy", busy, 3'b001);
        while (busy != '0) begin
            check_value("notes while held", played, 1);
            check_value("audio[1]", audio[1], 0);  // Only one voice sounds.
            saw_low |= (audio == 2'd0);
            saw_high |= (audio == 2'd1);
            step();
        end
        check_value("audio toggled", {saw_low, saw_high}, 2'b11);
        wait_for_entry(1, 8, cycles);
        check_value("cycles from note_done to new_note", cycles, 3);
    endtask

    // Entries 1 to 3 form a chord, one voice each.
    task automatic chord_fill_order();
        int cycles;
        step();
        step();
        check_value("busy", busy, 3'b001);
        wait_for_entry(2, 8, cycles);
        check_value("cycles between chord notes", cycles, 1);
        step();
        step();
        check_value("busy", busy, 3'b011);
        wait_for_entry(3, 8, cycles);
        check_value("cycles between chord notes", cycles, 1);
        step();
        step();
        check_value("busy", busy, 3'b111);
    endtask

    task automatic rest_voice_silent();
        int cycles;
        int voice;
        wait_for_entry(4, NOTE_LIMIT, cycles);
        voice = lowest_idle(busy);
        step();
        step();
        check_value("busy of rest voice", busy[voice], 1);
        while (busy[voice] && played == 5) begin
            if (int'(audio) >= busy_count(busy)) begin
                $display("FAIL audio: got 0x%0h, expected below 0x%0h",
                         audio, busy_count(busy));
                abort_run();
            end
            step();
        end
    endtask

    // Entry 9 is unheld, so two cycles after it the reader fetches entry 10.
    task automatic pause_and_resume();
        int          cycles;
        int unsigned pause;
        wait_for_entry(9, NOTE_LIMIT, cycles);
        step();
        step();
        play = 1'b0;  // Entry 10 is fetched but not issued.
        pause = 5 + ($urandom % (MAX_PAUSE - 4));
        repeat (pause) begin
            step();
            check_value("notes while paused", played, 10);
        end
        play = 1'b1;
        wait_for_entry(10, 8, cycles);
        check_value("cycles from play to new_note", cycles, 2);
    endtask

    task automatic song_end_and_switch();
        int cycles;
        cycles = 0;
        while (done_seen == 0) begin
            if (cycles >= song_cycles(1)) begin
                $display("song_done did not arrive at the end of song 1.");
                abort_run();
            end else begin
                step();
                cycles++;
            end
        end
        step();
        check_value("song_done", song_done, 0);
        repeat (AFTER_END_CYCLES) begin
            step();
        end
        check_value("notes after song end", played, 0);
        check_value("song_done pulses", done_seen, 1);
        song = 2'd2;
        wait_for_entry(0, 8, cycles);
        check_value("cycles from song select to new_note", cycles, 2);
        wait_for_entry(2, 3 * NOTE_LIMIT, cycles);
        play = 1'b0;
        repeat (4) begin
            step();
        end
    endtask

    initial begin
        played = 0;
        done_seen = 0;
        rst_n = 1'b0;
        play = 1'b0;
        song = 2'd1;
        for (int i = 0; i < 128; i++) begin
            model_rom[i] = '0;
        end
        $readmemh("songs.mem", model_rom);
        void'($urandom(32'h1064_2ec9));
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        held_note_and_tone();
        chord_fill_order();
        rest_voice_silent();
        pause_and_resume();
        song_end_and_switch();
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : watchdog
        int limit;
        #1;  // Model ROM is loaded by now.
        limit = RESET_CYCLES + IDLE_CYCLES + MAX_PAUSE + AFTER_END_CYCLES
                + song_cycles(1) + song_cycles(2) + 1000;
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles.", limit);
        abort_run();
    end

endmodule

`default_nettype wire

// File: hdl/music_player.sv
`timescale 1ns/10ps
`default_nettype none

module music_player (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               play,
    input  logic [1:0]                         song,
    output logic                               song_done,
    output logic                               new_note,
    output synth_pkg::note_event_t             note_event,
    output logic [synth_pkg::NUM_VOICES-1:0]   busy,
    output logic [1:0]                         audio
);
    import song_pkg::*;
    import synth_pkg::*;

    logic [SONG_W+1:0]     rom_addr;
    rom_entry_t            rom_data;
    logic                  beat;
    logic [NUM_VOICES-1:0] start;
    note_event_t           voice_note;
    logic [NUM_VOICES-1:0] note_done;
    logic [NUM_VOICES-1:0] wave;

    song_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .dout (rom_data)
    );

    song_reader u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .song      (song),
        .note_done (|note_done),  // Any voice finishing.
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .new_note  (new_note),
        .note_out  (note_event),
        .song_done (song_done)
    );

    beat_generator u_beat (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat)
    );

    voice_allocator u_alloc (
        .clk      (clk),
        .rst_n    (rst_n),
        .new_note (new_note),
        .note_in  (note_event),
        .busy     (busy),
        .start    (start),
        .note_out (voice_note)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        note_player u_player (
            .clk       (clk),
            .rst_n     (rst_n),
            .beat      (beat),
            .start     (start[v]),
            .note_in   (voice_note),
            .busy      (busy[v]),
            .note_done (note_done[v]),
            .wave      (wave[v])
        );
    end

    // Count of voices whose square wave is high.
    always_comb begin
        audio = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            audio = audio + 2'(wave[v]);
        end
    end

endmodule

`default_nettype wire

// File: hdl/note_player.sv
`timescale 1ns/10ps
`default_nettype none

module note_player (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    beat,
    input  logic                    start,
    input  synth_pkg::note_event_t  note_in,
    output logic                    busy,
    output logic                    note_done,
    output logic                    wave
);
    import song_pkg::*;
    import synth_pkg::*;

    logic [DUR_W-1:0]   count;   // Beats left after the current one.
    logic [PHASE_W-1:0] step;
    logic [PHASE_W-1:0] phase;
    logic               last_beat;

    assign last_beat = busy && beat && (count == '0);

    // A new start takes the voice over, even on its final beat.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            count     <= '0;
            note_done <= 1'b0;
        end else begin
            note_done <= last_beat && !start;
            if (start) begin
                busy  <= 1'b1;
                count <= note_in.duration;
            end else if (last_beat) begin
                busy <= 1'b0;  // Drops together with note_done.
            end else if (busy && beat) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            step  <= pitch_step(note_in.note);
            phase <= '0;
        end else if (busy) begin
            phase <= phase + step;
        end
    end

    // Square wave from the accumulator MSB.
    // A rest has step 0, so phase stays at 0.
    assign wave = busy && phase[PHASE_W-1];

endmodule

`default_nettype wire

// File: hdl/voice_allocator.sv
`timescale 1ns/10ps
`default_nettype none

module voice_allocator (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               new_note,
    input  synth_pkg::note_event_t             note_in,
    input  logic [synth_pkg::NUM_VOICES-1:0]   busy,
    output logic [synth_pkg::NUM_VOICES-1:0]   start,
    output synth_pkg::note_event_t             note_out
);
    import synth_pkg::*;

    logic [NUM_VOICES-1:0] pick;

    // Lowest idle voice wins. With every voice busy, voice 0 is stolen.
    always_comb begin
        pick = NUM_VOICES'(1);
        for (int i = NUM_VOICES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                pick = NUM_VOICES'(1) << i;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= '0;
        end else begin
            start <= new_note ? pick : '0;  // One-cycle strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (new_note) begin
            note_out <= note_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/beat_generator.sv
`timescale 1ns/10ps
`default_nettype none

module beat_generator #(
    parameter int PERIOD = synth_pkg::BEAT_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    output logic beat
);

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0] count;

    assign beat = (count == CNT_W'(PERIOD - 1));  // Last cycle of each period.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (beat) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/song_reader.sv
`timescale 1ns/10ps
`default_nettype none

module song_reader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          play,
    input  logic [1:0]                    song,
    input  logic                          note_done,
    output logic [song_pkg::SONG_W+1:0]   rom_addr,
    input  song_pkg::rom_entry_t          rom_data,
    output logic                          new_note,
    output synth_pkg::note_event_t        note_out,
    output logic                          song_done
);
    import song_pkg::*;

    reader_state_t     state;
    reader_state_t     next;
    logic [SONG_W-1:0] entry;
    logic [SONG_W-1:0] next_entry;
    logic              advance;
    logic              overflow;
    logic              ended;       // Song finished, hold off a restart.
    logic [1:0]        ended_song;
    logic              may_start;

    assign rom_addr = {song, entry};

    // A finished song does not loop while play stays high.
    assign may_start = play && !(ended && (song == ended_song));

    always_comb begin
        case (state)
            PAUSED:        next = may_start ? RETRIEVE_NOTE : PAUSED;
            RETRIEVE_NOTE: next = play ? NEW_NOTE_READY : PAUSED;
            NEW_NOTE_READY: begin
                if (!play) begin
                    next = PAUSED;
                end else if (rom_data.hold) begin
                    next = WAIT;
                end else begin
                    next = INCREMENT_ADDRESS;  // Next entry joins the chord.
                end
            end
            WAIT: begin
                if (!play) begin
                    next = PAUSED;
                end else if (note_done) begin
                    next = INCREMENT_ADDRESS;
                end else begin
                    next = WAIT;
                end
            end
            INCREMENT_ADDRESS: next = (play && !overflow) ? RETRIEVE_NOTE : PAUSED;
            default:           next = PAUSED;
        endcase
    end

    // Only INCREMENT_ADDRESS moves the entry counter.
    assign advance = (state == INCREMENT_ADDRESS);

    assign {overflow, next_entry} = advance ? {1'b0, entry} + (SONG_W + 1)'(1)
                                            : {1'b0, entry};

    assign song_done = overflow;  // Wrap past entry 31.
    assign new_note = (state == NEW_NOTE_READY);
    assign note_out.note = rom_data.note;
    assign note_out.duration = rom_data.duration;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PAUSED;
            entry <= '0;
            ended <= 1'b0;
        end else begin
            state <= next;
            entry <= next_entry;
            if (overflow) begin
                ended <= 1'b1;
            end else if (!play || (song != ended_song)) begin
                ended <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (overflow) begin
            ended_song <= song;
        end
    end

endmodule

`default_nettype wire

// File: hdl/song_rom.sv
`timescale 1ns/10ps
`default_nettype none

module song_rom (
    input  logic                          clk,
    input  logic [song_pkg::SONG_W+1:0]   addr,
    output song_pkg::rom_entry_t          dout
);
    import song_pkg::*;

    rom_entry_t mem [ROM_WORDS];

    // Words missing from the image read as zero.
    initial begin
        for (int i = 0; i < ROM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh("songs.mem", mem);
    end

    always_ff @(posedge clk) begin
        dout <= mem[addr];  // One cycle read latency.
    end

endmodule

`default_nettype wire

// File: hdl/synth_pkg.sv
`default_nettype none

package synth_pkg;

    localparam int NUM_VOICES = 3;
    localparam int BEAT_CYCLES = 64;  // Short beat for simulation.
    localparam int PHASE_W = 16;

    typedef struct packed {
        logic [song_pkg::NOTE_W-1:0] note;
        logic [song_pkg::DUR_W-1:0]  duration;
    } note_event_t;

    // Lowest octave steps, scaled by equal temperament from 512.
    // Higher octaves shift the base step left.
    function automatic logic [PHASE_W-1:0] pitch_step(input logic [song_pkg::NOTE_W-1:0] note);
        int                 idx;
        int                 octave;
        logic [PHASE_W-1:0] base;
        if (note == '0) begin
            return '0;  // Rest.
        end
        idx = int'(note) - 1;
        octave = idx / 12;
        case (idx % 12)
            0:       base = PHASE_W'(512);
            1:       base = PHASE_W'(542);
            2:       base = PHASE_W'(575);
            3:       base = PHASE_W'(609);
            4:       base = PHASE_W'(645);
            5:       base = PHASE_W'(683);
            6:       base = PHASE_W'(724);
            7:       base = PHASE_W'(767);
            8:       base = PHASE_W'(813);
            9:       base = PHASE_W'(861);
            10:      base = PHASE_W'(912);
            default: base = PHASE_W'(967);
        endcase
        return base << octave;
    endfunction

endpackage

`default_nettype wire

// File: hdl/song_pkg.sv
`default_nettype none

package song_pkg;

    localparam int SONG_W = 5;  // Entries per song, as address bits.
    localparam int NOTE_W = 6;
    localparam int DUR_W = 6;

    // Four songs back to back in one ROM.
    localparam int ROM_WORDS = 4 << SONG_W;

    // One 16-bit ROM word, hold flag in the top bit.
    typedef struct packed {
        logic              hold;      // Wait for note_done before moving on.
        logic [NOTE_W-1:0] note;      // 0 is a rest.
        logic [DUR_W-1:0]  duration;  // In beats.
        logic [2:0]        spare;
    } rom_entry_t;

    // Reader FSM states.
    typedef enum logic [2:0] {
        PAUSED            = 3'b000,
        WAIT              = 3'b001,
        INCREMENT_ADDRESS = 3'b010,
        RETRIEVE_NOTE     = 3'b011,
        NEW_NOTE_READY    = 3'b100
    } reader_state_t;

endpackage

`default_nettype wire
